/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := fetch_frontend_tb
FILELIST  := project.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* hdl/cacheline_adapter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module cacheline_adapter (
    input  logic             clk,
    input  logic             rst,
    input  mem_pkg::beat_t   bmem_rdata_i,
    input  logic             bmem_rvalid_i,
    output mem_pkg::line_t   line_o,
    output logic             line_valid_o
);

    localparam int CNT_W  = $clog2(`BURST_BEATS);
    localparam int BEAT_W = $bits(mem_pkg::beat_t);
    localparam int LINE_W = $bits(mem_pkg::line_t);

    logic [CNT_W-1:0] count_q;
    mem_pkg::line_t   line_q;
    logic             valid_q;
    logic             last_beat;

    assign last_beat = bmem_rvalid_i && (count_q == CNT_W'(`BURST_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= last_beat; // line complete one cycle after the last beat
            if (last_beat) begin
                count_q <= '0;
            end else if (bmem_rvalid_i) begin
                count_q <= count_q + CNT_W'(1);
            end
        end
    end

    // beats enter at the top, so the first beat ends up in the low bits
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[LINE_W-1:BEAT_W]};
        end
    end

    assign line_o       = line_q;
    assign line_valid_o = valid_q;

endmodule : cacheline_adapter

`default_nettype wire

/* hdl/fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               q_full_i,
    input  logic               resp_i,
    input  logic               redirect_i,
    input  fetch_pkg::addr_t   redirect_pc_i,
    output logic               req_o,
    output fetch_pkg::addr_t   pc_o,
    output logic               enq_o,
    output fetch_pkg::addr_t   enq_pc_o,
    output logic               flush_o
);

    fetch_pkg::addr_t pc_q;
    fetch_pkg::addr_t req_pc_q;   // pc of the outstanding request
    logic             pending_q;
    logic             stale_q;    // outstanding request predates a redirect
    logic             issue;

    // one request in flight at most, so a full queue never overflows
    assign issue = !rst && !pending_q && !redirect_i && !q_full_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q      <= `RESET_PC;
            pending_q <= 1'b0;
            stale_q   <= 1'b0;
        end else begin
            if (issue) begin
                pending_q <= 1'b1;
            end else if (resp_i) begin
                pending_q <= 1'b0;
            end
            if (resp_i) stale_q <= 1'b0;

            if (redirect_i) begin
                pc_q <= redirect_pc_i;
                if (pending_q && !resp_i) begin
                    stale_q <= 1'b1; // fill still completes, its word is dropped
                end
            end else if (resp_i && !stale_q) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) req_pc_q <= pc_q;
    end

    assign req_o    = issue;
    assign pc_o     = pc_q;
    assign enq_o    = resp_i && !stale_q && !redirect_i;
    assign enq_pc_o = req_pc_q;
    assign flush_o  = redirect_i;

endmodule : fetch_ctrl

`default_nettype wire

/* hdl/fetch_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
    input  logic               clk,
    input  logic               rst,

    output fetch_pkg::addr_t   bmem_addr_o,
    output logic               bmem_read_o,
    input  logic               bmem_ready_i,
    input  mem_pkg::beat_t     bmem_rdata_i,
    input  logic               bmem_rvalid_i,

    input  logic               redirect_i,
    input  fetch_pkg::addr_t   redirect_pc_i,

    input  logic               deq_i,
    output fetch_pkg::inst_t   inst_o,
    output fetch_pkg::addr_t   inst_pc_o,
    output logic               empty_o
);

    logic               req;
    fetch_pkg::addr_t   pc;
    logic               resp;
    fetch_pkg::inst_t   rdata;
    logic               enq;
    fetch_pkg::addr_t   enq_pc;
    logic               flush;
    logic               q_full;
    logic               line_valid;
    mem_pkg::line_t     line;

    fetch_ctrl fetch_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .q_full_i      (q_full),
        .resp_i        (resp),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .req_o         (req),
        .pc_o          (pc),
        .enq_o         (enq),
        .enq_pc_o      (enq_pc),
        .flush_o       (flush)
    );

    line_buffer line_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req),
        .addr_i       (pc),
        .resp_o       (resp),
        .rdata_o      (rdata),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_ready_i (bmem_ready_i),
        .line_valid_i (line_valid),
        .line_i       (line)
    );

    cacheline_adapter cacheline_adapter_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_o        (line),
        .line_valid_o  (line_valid)
    );

    fetch_queue #(.payload_t(fetch_pkg::inst_t)) inst_q (
        .clk     (clk),
        .rst     (rst),
        .flush_i (flush),
        .enq_i   (enq),
        .wdata_i (rdata),
        .deq_i   (deq_i),
        .rdata_o (inst_o),
        .full_o  (q_full),
        .empty_o (empty_o)
    );

    // moves in lockstep with inst_q, flags not needed
    fetch_queue #(.payload_t(fetch_pkg::addr_t)) pc_q (
        .clk     (clk),
        .rst     (rst),
        .flush_i (flush),
        .enq_i   (enq),
        .wdata_i (enq_pc),
        .deq_i   (deq_i),
        .rdata_o (inst_pc_o),
        .full_o  (),
        .empty_o ()
    );

endmodule : fetch_frontend

`default_nettype wire

/* hdl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // byte address, fetch addresses are always 4-aligned
    typedef logic [31:0] addr_t;

    // raw RV32I instruction word
    typedef logic [31:0] inst_t;

endpackage : fetch_pkg

`default_nettype wire

/* hdl/fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_queue #(
    parameter type payload_t = logic [31:0]
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush_i,
    input  logic       enq_i,
    input  payload_t   wdata_i,
    input  logic       deq_i,
    output payload_t   rdata_o,
    output logic       full_o,
    output logic       empty_o
);

    localparam int DEPTH = `IQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;
    logic             do_enq;
    logic             do_deq;

    assign full_o  = (count_q == (PTR_W+1)'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_enq  = enq_i && !full_o;
    assign do_deq  = deq_i && !empty_o; // deq on empty is dropped

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_enq) tail_q <= tail_q + PTR_W'(1);
            if (do_deq) head_q <= head_q + PTR_W'(1);
            case ({do_enq, do_deq})
                2'b10:   count_q <= count_q + (PTR_W+1)'(1);
                2'b01:   count_q <= count_q - (PTR_W+1)'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq && !flush_i) begin
            mem_q[tail_q] <= wdata_i;
        end
    end

    assign rdata_o = mem_q[head_q]; // show-ahead

endmodule : fetch_queue

`default_nettype wire

/* hdl/line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_i,
    input  fetch_pkg::addr_t   addr_i,
    output logic               resp_o,
    output fetch_pkg::inst_t   rdata_o,
    output fetch_pkg::addr_t   bmem_addr_o,
    output logic               bmem_read_o,
    input  logic               bmem_ready_i,
    input  logic               line_valid_i,
    input  mem_pkg::line_t     line_i
);

    logic               valid_q;
    mem_pkg::tag_t      tag_q;
    mem_pkg::line_t     line_q;
    logic               miss_q;   // waiting on a fill
    logic               sent_q;   // read already accepted for this miss
    fetch_pkg::addr_t   addr_q;
    logic               resp_q;
    fetch_pkg::inst_t   rdata_q;
    logic               hit;

    function automatic fetch_pkg::inst_t word_sel(input mem_pkg::line_t line,
                                                  input logic [2:0] idx);
        return line[idx*32 +: 32];
    endfunction

    assign hit = valid_q && (tag_q == addr_i[31:5]);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            miss_q  <= 1'b0;
            sent_q  <= 1'b0;
            resp_q  <= 1'b0;
        end else begin
            resp_q <= 1'b0;
            if (req_i && hit) begin
                resp_q <= 1'b1;
            end else if (req_i) begin
                miss_q <= 1'b1;
                sent_q <= 1'b0;
            end
            if (bmem_read_o) sent_q <= 1'b1;
            if (miss_q && line_valid_i) begin
                valid_q <= 1'b1;
                miss_q  <= 1'b0;
                resp_q  <= 1'b1; // answer the cycle after the fill lands
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_i && hit) begin
            rdata_q <= word_sel(line_q, addr_i[4:2]);
        end else if (req_i) begin
            addr_q <= addr_i;
        end
        if (miss_q && line_valid_i) begin
            line_q  <= line_i;
            tag_q   <= addr_q[31:5];
            rdata_q <= word_sel(line_i, addr_q[4:2]);
        end
    end

    assign bmem_read_o = miss_q && !sent_q && bmem_ready_i;
    assign bmem_addr_o = {addr_q[31:5], 5'b0};
    assign resp_o      = resp_q;
    assign rdata_o     = rdata_q;

endmodule : line_buffer

`default_nettype wire

/* hdl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // one beat on the burst read bus
    typedef logic [63:0] beat_t;

    // word k sits at bits 32k upward
    // the low word of each beat is the lower address
    typedef logic [255:0] line_t;

    // address bits above the 5 byte-offset bits
    typedef logic [26:0] tag_t;

endpackage : mem_pkg

`default_nettype wire

/* include/fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// first fetch address after reset, must stay 4-aligned
`define RESET_PC 32'h1eceb000

// entries in each fetch queue, power of two
`define IQ_DEPTH 16

// 64-bit beats that make up one 256-bit line
`define BURST_BEATS 4

`endif

/* project.f */
+incdir+include
hdl/mem_pkg.sv
hdl/fetch_pkg.sv
hdl/cacheline_adapter.sv
hdl/line_buffer.sv
hdl/fetch_queue.sv
hdl/fetch_ctrl.sv
hdl/fetch_frontend.sv
tests/fetch_frontend_sva.sv
tests/fetch_frontend_tb.sv

/* tests/fetch_frontend_sva.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_frontend_sva (
    input  logic   clk,
    input  logic   rst,
    input  logic   bmem_read_i,
    input  logic   bmem_ready_i,
    input  logic   bmem_rvalid_i,
    input  logic   empty_i
);

    localparam int BEATS = `BURST_BEATS;

    int unsigned fail_count = 0;
    logic [3:0]  beats_q;   // beats seen since the last read

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_q <= 4'(BEATS);
        end else if (bmem_read_i) begin
            beats_q <= '0;
        end else if (bmem_rvalid_i && beats_q != 4'(BEATS)) begin
            beats_q <= beats_q + 4'd1;
        end
    end

    read_needs_ready: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> bmem_ready_i)
        else begin
            fail_count++;
            $error("bmem_read_o asserted while bmem_ready_i low");
        end

    read_single_cycle: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |=> !bmem_read_i)
        else begin
            fail_count++;
            $error("bmem_read_o held for more than one cycle");
        end

    // a new burst only after the previous one delivered all beats
    read_after_burst: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> beats_q == 4'(BEATS))
        else begin
            fail_count++;
            $error("second bmem_read_o before the burst completed");
        end

    empty_after_reset: assert property (@(posedge clk) rst |=> empty_i)
        else begin
            fail_count++;
            $error("empty_o low in the cycle after reset");
        end

endmodule : fetch_frontend_sva

bind fetch_frontend fetch_frontend_sva fetch_sva (
    .clk           (clk),
    .rst           (rst),
    .bmem_read_i   (bmem_read_o),
    .bmem_ready_i  (bmem_ready_i),
    .bmem_rvalid_i (bmem_rvalid_i),
    .empty_i       (empty_o)
);

`default_nettype wire

/* tests/fetch_frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_frontend_tb;

    // directed phases take about 1000 cycles, 30 mix episodes about 8500
    localparam int CYCLE_LIMIT = 20000;
    localparam int EPISODES    = 30;

    logic             clk;
    logic             rst;
    fetch_pkg::addr_t bmem_addr;
    logic             bmem_read;
    logic             bmem_ready;
    mem_pkg::beat_t   bmem_rdata;
    logic             bmem_rvalid;
    logic             redirect;
    fetch_pkg::addr_t redirect_pc;
    logic             deq;
    fetch_pkg::inst_t inst;
    fetch_pkg::addr_t inst_pc;
    logic             empty;

    fetch_pkg::addr_t exp_pc;          // pc expected at the queue head
    int unsigned      reads     = 0;
    int unsigned      redirects = 0;
    int unsigned      cycles    = 0;
    int unsigned      reads_base;
    int unsigned      redir_base;
    logic [31:0]      last_line;       // line held by the buffer at the last checkpoint

    fetch_frontend UUT (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .deq_i         (deq),
        .inst_o        (inst),
        .inst_pc_o     (inst_pc),
        .empty_o       (empty)
    );

    // memory contents, a fixed scramble of the word address
    function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::addr_t addr);
        fetch_pkg::inst_t w;
        w = addr * 32'h9e3779b1;
        return w ^ {addr[15:0], addr[31:16]} ^ 32'h0badf00d;
    endfunction

    function automatic fetch_pkg::addr_t pick_target();
        return `RESET_PC + 32'(($urandom % 2048) * 4);
    endfunction

    task automatic stop_run(input string why);
        $display("tests failed");
        $fatal(1, "%s", why);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
        stop_run("value mismatch");
    endtask

    // hold deq low until the queue fills, then check fetch stopped and the read count
    task automatic fill_and_count();
        logic [31:0] line_now;
        @(posedge clk);
        deq      <= 1'b0;
        redirect <= 1'b0;
        do @(posedge clk); while (!UUT.inst_q.full_o);
        repeat (20) @(posedge clk);
        @(negedge clk);
        assert (UUT.inst_q.full_o)
            else stop_run("instruction queue left the full state while deq was held low");
        line_now = (exp_pc + 32'(4 * (`IQ_DEPTH - 1))) >> 5;
        if (redirects == redir_base) begin   // sequential segment, each new line read once
            assert (reads - reads_base == line_now - last_line)
                else report_mismatch("bmem_read_o count", reads - reads_base,
                                     line_now - last_line);
        end
        reads_base = reads;
        redir_base = redirects;
        last_line  = line_now;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        bmem_ready <= ($urandom % 4) != 0;
    end

    // burst memory, four beats per accepted read with random gaps
    initial begin : mem_model
        fetch_pkg::addr_t base;
        int               gap;
        int               b;
        forever begin
            @(posedge clk);
            if (!rst && bmem_read) begin
                base = bmem_addr;
                for (b = 0; b < `BURST_BEATS; b++) begin
                    gap = (b == 0) ? 1 + int'($urandom % 5) : int'($urandom % 3);
                    repeat (gap) begin
                        @(posedge clk);
                        bmem_rvalid <= 1'b0;
                    end
                    @(posedge clk);
                    bmem_rvalid <= 1'b1;
                    bmem_rdata  <= {mem_word(base + 32'(8 * b + 4)), mem_word(base + 32'(8 * b))};
                end
                @(posedge clk);
                bmem_rvalid <= 1'b0;
            end
        end
    end

    // comparer
    always @(posedge clk) begin
        if (rst) begin
            exp_pc = `RESET_PC;
        end else begin
            if (deq && !empty) begin
                assert (inst_pc == exp_pc)
                    else report_mismatch("inst_pc_o", inst_pc, exp_pc);
                assert (inst == mem_word(exp_pc))
                    else report_mismatch("inst_o", inst, mem_word(exp_pc));
                exp_pc = exp_pc + 32'd4;
            end
            if (redirect) begin
                exp_pc = redirect_pc;
                redirects++;
            end
            if (bmem_read) reads++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == CYCLE_LIMIT) stop_run("timeout, the run did not finish within the cycle limit");
        if (UUT.fetch_sva.fail_count != 0) stop_run("a bound assertion on the DUT failed");
    end

    initial begin : stimulus
        int ep;
        rst         = 1'b1;
        deq         = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        bmem_ready  = 1'b0;
        bmem_rdata  = '0;
        bmem_rvalid = 1'b0;
        reads_base  = 0;
        redir_base  = 0;
        last_line   = (`RESET_PC >> 5) - 32'd1;   // nothing buffered yet
        void'($urandom(32'hd6b));
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        deq <= 1'b1;
        repeat (300) @(posedge clk);

        fill_and_count();
        @(posedge clk);
        deq <= 1'b1;
        do @(posedge clk); while (!empty);

        repeat ($urandom % 20) @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= pick_target();
        @(posedge clk);
        redirect <= 1'b0;
        do @(posedge clk); while (!bmem_read);
        redirect    <= 1'b1;   // lands while the fill is still outstanding
        redirect_pc <= pick_target();
        @(posedge clk);
        redirect <= 1'b0;
        repeat (100) @(posedge clk);
        fill_and_count();

        for (ep = 0; ep < EPISODES; ep++) begin
            repeat (200) begin
                @(posedge clk);
                deq <= ($urandom % 3) != 0;
                if (!redirect && ($urandom % 400) == 0) begin
                    redirect    <= 1'b1;
                    redirect_pc <= pick_target();
                end else begin
                    redirect <= 1'b0;
                end
            end
            fill_and_count();
        end

        @(negedge clk);
        if (UUT.fetch_sva.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            stop_run("bound assertions reported failures");
        end
    end

endmodule : fetch_frontend_tb

`default_nettype wire
